//--- cpu8_top.f
+incdir+.
cpu8_pkg.sv
cpu8_alu.sv
cpu8_mem.sv
cpu8_core.sv
cpu8_top.sv
tb_cpu8.sv

//--- run_sim.sh
#!/bin/sh
# build the cpu8 testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cpu8 -f cpu8_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_cpu8 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- tb_cpu8.sv
// directed testbench of the 8-bit cpu
// loads programs over the host port, runs them and checks every retire trace
// against a software model of the instruction set, then reads memory back
`include "cpu8_cfg.svh"

module tb_cpu8;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD       = 8;
  localparam int MAX_INSTR_CYCLES = 4 * (`CPU8_MEM_WAIT + 2);  // imm form plus data access
  localparam int NUM_INSTR        = 40;                        // retires over all tests
  localparam int WATCHDOG_NS      = (NUM_INSTR * MAX_INSTR_CYCLES + 600) * CLK_PERIOD;

  logic                in_clk;
  logic                in_rst;
  logic                run;
  cpu8_pkg::host_req_t host_req;
  cpu8_pkg::host_rsp_t host_rsp;
  cpu8_pkg::trace_t    trace;

  integer          seed;
  int              errors;
  int              checks;
  cpu8_pkg::word_t load_addr;                  // next host write address
  cpu8_pkg::word_t m_regs [`CPU8_NUM_REGS];    // model registers, 0 is the pc
  cpu8_pkg::word_t m_mem  [`CPU8_MEM_WORDS];   // model memory image

  cpu8_top cpu8_top_inst (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .run      (run),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .trace    (trace)
  );

  initial in_clk = 1'b0;
  always #(CLK_PERIOD / 2) in_clk = ~in_clk;

  // ------------------------------------------------------------
  // encoders and model
  // ------------------------------------------------------------
  function automatic cpu8_pkg::instr_u encode_rr(input cpu8_pkg::op2_e op,
                                                 input cpu8_pkg::reg_idx_t a,
                                                 input cpu8_pkg::reg_idx_t b);
    cpu8_pkg::instr_u w;
    w.r2.fmt = 1'b1;  // two-register layout
    w.r2.op  = op;
    w.r2.a   = a;
    w.r2.b   = b;
    return w;
  endfunction

  function automatic cpu8_pkg::instr_u encode_r(input logic imm, input cpu8_pkg::op1_e op,
                                                input cpu8_pkg::reg_idx_t a);
    cpu8_pkg::instr_u w;
    w.r1.fmt = 1'b0;
    w.r1.imm = imm;
    w.r1.op  = op;
    w.r1.a   = a;
    return w;
  endfunction

  // fetch from the model image, execute, return the expected retire
  function automatic cpu8_pkg::trace_t model_step();
    cpu8_pkg::instr_u ins;
    cpu8_pkg::word_t  imm;
    cpu8_pkg::word_t  a;
    cpu8_pkg::word_t  b;
    cpu8_pkg::word_t  v;
    cpu8_pkg::trace_t t;
    ins       = m_mem[m_regs[0]];
    m_regs[0] = m_regs[0] + 8'd1;
    imm       = '0;
    v         = '0;
    if (!ins.r1.fmt && ins.r1.imm) begin
      imm       = m_mem[m_regs[0]];  // second word
      m_regs[0] = m_regs[0] + 8'd1;
    end
    t       = '0;
    t.valid = 1'b1;
    t.instr = ins;
    if (ins.r2.fmt) begin
      a       = m_regs[ins.r2.a];
      b       = m_regs[ins.r2.b];
      t.wrote = 1'b1;
      t.dest  = ins.r2.a;
      case (ins.r2.op)
        cpu8_pkg::OP2_MOV: begin
          t.dest = ins.r2.b;
          v      = a;
        end
        cpu8_pkg::OP2_ADD: v = a + b;
        cpu8_pkg::OP2_SUB: v = a - b;
        cpu8_pkg::OP2_SHL: v = (b > 8'd7) ? 8'd0 : a << b[2:0];
        cpu8_pkg::OP2_SHR: v = (b > 8'd7) ? 8'd0 : a >> b[2:0];
        cpu8_pkg::OP2_CMP: begin
          t.dest = 2'd3;
          // bits eq ne lt le gt ge, one pattern per ordering
          if (a == b) begin
            v = 8'b0010_0101;  // eq le ge
          end else if (a < b) begin
            v = 8'b0001_1100;  // ne lt le
          end else begin
            v = 8'b0001_0011;  // ne gt ge
          end
        end
        cpu8_pkg::OP2_AND: v = a & b;
        default:           v = a | b;
      endcase
    end else begin
      a      = m_regs[ins.r1.a];
      t.dest = ins.r1.a;
      if (ins.r1.imm) begin
        if (ins.r1.op == cpu8_pkg::OP1_LDI) begin
          t.wrote = 1'b1;
          v       = imm;
        end else if (ins.r1.op == cpu8_pkg::OP1_LDM) begin
          t.wrote = 1'b1;
          v       = m_mem[imm];
        end else if (ins.r1.op == cpu8_pkg::OP1_STM) begin
          m_mem[imm] = a;  // no register change
        end
      end else if (ins.r1.op == cpu8_pkg::OP1_NOT) begin
        t.wrote = 1'b1;
        v       = ~a;
      end else if (ins.r1.op == cpu8_pkg::OP1_LNOT) begin
        t.wrote = 1'b1;
        v       = (a == 8'd0) ? 8'd1 : 8'd0;
      end
    end
    if (t.wrote) begin
      t.value        = v;
      m_regs[t.dest] = v;  // reg 0 here is a jump
    end
    return t;
  endfunction

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  task automatic check_trace(input string name, input cpu8_pkg::trace_t exp,
                             input cpu8_pkg::trace_t act);
    logic bad;
    checks++;
    bad = (act.valid !== 1'b1) || (exp.instr !== act.instr) || (exp.wrote !== act.wrote);
    if (exp.wrote) begin
      bad = bad || (exp.dest !== act.dest) || (exp.value !== act.value);  // dest only if written
    end
    if (bad) begin
      errors++;
      $display("Error %s: expected instr %h wrote %b dest %0d value %h", name,
               exp.instr, exp.wrote, exp.dest, exp.value);
      $display("      actual instr %h wrote %b dest %0d value %h",
               act.instr, act.wrote, act.dest, act.value);
    end
  endtask

  task automatic check_word(input string name, input cpu8_pkg::word_t exp,
                            input cpu8_pkg::word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  // ------------------------------------------------------------
  // drivers
  // ------------------------------------------------------------
  task automatic reset_dut();
    @(negedge in_clk);
    in_rst = 1'b1;
    run    = 1'b0;
    repeat (4) @(negedge in_clk);
    in_rst    = 1'b0;
    load_addr = '0;
    for (int i = 0; i < `CPU8_NUM_REGS; i++) begin
      m_regs[i] = '0;
    end
  endtask

  // one host cycle, ready comes back one clock after valid
  task automatic host_access(input logic wr, input cpu8_pkg::word_t addr,
                             input cpu8_pkg::word_t wdata, output cpu8_pkg::word_t rdata);
    @(negedge in_clk);
    host_req.valid = 1'b1;
    host_req.write = wr;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    @(negedge in_clk);
    while (!host_rsp.ready) @(negedge in_clk);
    rdata          = host_rsp.rdata;
    host_req.valid = 1'b0;
  endtask

  task automatic emit(input cpu8_pkg::word_t w);
    cpu8_pkg::word_t unused;
    host_access(1'b1, load_addr, w, unused);
    m_mem[load_addr] = w;
    load_addr        = load_addr + 8'd1;
  endtask

  task automatic emit_ldi(input cpu8_pkg::reg_idx_t r, input cpu8_pkg::word_t val);
    emit(encode_r(1'b1, cpu8_pkg::OP1_LDI, r));
    emit(val);
  endtask

  // run until count retires, run drops on the last one so the core parks
  task automatic run_prog(input string name, input int count);
    int               seen;
    cpu8_pkg::trace_t exp;
    seen = 0;
    @(negedge in_clk);
    run = 1'b1;
    while (seen < count) begin
      @(negedge in_clk);
      if (trace.valid) begin
        exp = model_step();
        check_trace(name, exp, trace);
        seen++;
        if (seen == count) run = 1'b0;
      end
    end
    repeat (2) @(negedge in_clk);
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic test_host();
    cpu8_pkg::word_t a;
    cpu8_pkg::word_t d;
    cpu8_pkg::word_t r;
    reset_dut();
    for (int i = 0; i < 10; i++) begin
      @(negedge in_clk);
      if ((trace.valid !== 1'b0) || (host_rsp.ready !== 1'b0)) begin
        errors++;
        $display("test_host: trace or host ready seen with no request and run low");
      end
    end
    a = cpu8_pkg::word_t'($random(seed));
    d = cpu8_pkg::word_t'($random(seed));
    host_access(1'b1, a, d, r);
    host_access(1'b0, a, 8'h00, r);
    check_word("test_host readback", d, r);
  endtask

  task automatic test_alu();
    reset_dut();
    emit_ldi(2'd1, 8'h80 | cpu8_pkg::word_t'($random(seed)));  // both high, ADD wraps
    emit_ldi(2'd2, 8'h80 | cpu8_pkg::word_t'($random(seed)));
    emit(encode_rr(cpu8_pkg::OP2_MOV, 2'd1, 2'd3));
    emit(encode_rr(cpu8_pkg::OP2_ADD, 2'd1, 2'd2));
    emit(encode_rr(cpu8_pkg::OP2_SUB, 2'd3, 2'd2));
    emit_ldi(2'd2, 8'h07 & cpu8_pkg::word_t'($random(seed)));  // shift amount
    emit(encode_rr(cpu8_pkg::OP2_SHL, 2'd1, 2'd2));
    emit(encode_rr(cpu8_pkg::OP2_SHR, 2'd3, 2'd2));
    emit_ldi(2'd1, cpu8_pkg::word_t'($random(seed)));
    emit_ldi(2'd2, cpu8_pkg::word_t'($random(seed)));
    emit(encode_rr(cpu8_pkg::OP2_AND, 2'd1, 2'd2));
    emit(encode_rr(cpu8_pkg::OP2_OR, 2'd3, 2'd2));
    run_prog("test_alu", 12);
  endtask

  task automatic test_cmp();
    cpu8_pkg::word_t xa [5];
    cpu8_pkg::word_t xb [5];
    reset_dut();
    xa[0] = cpu8_pkg::word_t'($random(seed));
    xb[0] = cpu8_pkg::word_t'($random(seed));
    xa[1] = cpu8_pkg::word_t'($random(seed));
    xb[1] = xa[1];  // equal
    xa[2] = 8'h00;
    xb[2] = 8'hff;
    xa[3] = 8'hff;
    xb[3] = 8'h00;
    xa[4] = 8'h00;
    xb[4] = 8'h00;
    for (int i = 0; i < 5; i++) begin
      emit_ldi(2'd1, xa[i]);
      emit_ldi(2'd2, xb[i]);
      emit(encode_rr(cpu8_pkg::OP2_CMP, 2'd1, 2'd2));
    end
    run_prog("test_cmp", 15);
  endtask

  task automatic test_ldm_stm();
    cpu8_pkg::word_t addr;
    cpu8_pkg::word_t val;
    cpu8_pkg::word_t r;
    reset_dut();
    addr = 8'h80 | cpu8_pkg::word_t'($random(seed));  // clear of the program
    val  = cpu8_pkg::word_t'($random(seed));
    emit_ldi(2'd1, val);
    emit(encode_r(1'b1, cpu8_pkg::OP1_STM, 2'd1));
    emit(addr);
    emit(encode_r(1'b1, cpu8_pkg::OP1_LDM, 2'd2));
    emit(addr);
    run_prog("test_ldm_stm", 3);
    host_access(1'b0, addr, 8'h00, r);
    check_word("test_ldm_stm readback", val, r);
  endtask

  task automatic test_not_jump();
    cpu8_pkg::word_t target;
    reset_dut();
    target = 8'h60;
    emit_ldi(2'd1, 8'h00);
    emit(encode_r(1'b0, cpu8_pkg::OP1_NOT, 2'd1));   // 00 -> ff
    emit(encode_r(1'b0, cpu8_pkg::OP1_LNOT, 2'd1));  // nonzero -> 0
    emit(encode_r(1'b0, cpu8_pkg::OP1_LNOT, 2'd1));  // zero -> 1
    emit_ldi(2'd2, 8'h01 | cpu8_pkg::word_t'($random(seed)));
    emit(encode_r(1'b0, cpu8_pkg::OP1_NOT, 2'd2));
    emit_ldi(2'd3, target);
    emit(encode_rr(cpu8_pkg::OP2_MOV, 2'd3, 2'd0));  // pc = target
    load_addr = target;
    emit(8'b0_0_0011_01);  // one-register op 0011 is undefined
    emit_ldi(2'd1, 8'h5a);
    run_prog("test_not_jump", 10);
  endtask

  // ------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    seed      = 32'ha1c0_47b6;
    errors    = 0;
    checks    = 0;
    in_rst    = 1'b1;
    run       = 1'b0;
    host_req  = '0;
    load_addr = '0;
    test_host();
    test_alu();
    test_cmp();
    test_ldm_stm();
    test_not_jump();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: tests did not complete in %0d ns, a handshake never came", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule

//--- cpu8_top.sv
// top level of the 8-bit cpu
// core and alu beside the memory, run, host and trace ports brought out
module cpu8_top (
  input  logic                in_clk,
  input  logic                in_rst,
  input  logic                run,       // high lets the core fetch
  input  cpu8_pkg::host_req_t host_req,  // served only while run is low
  output cpu8_pkg::host_rsp_t host_rsp,
  output cpu8_pkg::trace_t    trace
);

  // core <-> memory
  cpu8_pkg::mem_req_t mem_req;
  cpu8_pkg::mem_rsp_t mem_rsp;

  // core <-> alu
  cpu8_pkg::instr_u   alu_instr;
  cpu8_pkg::word_t    alu_a;
  cpu8_pkg::word_t    alu_b;
  cpu8_pkg::word_t    alu_imm;
  cpu8_pkg::alu_out_t alu_res;

  cpu8_core cpu8_core_inst (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .run       (run),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .alu_instr (alu_instr),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_imm   (alu_imm),
    .alu_res   (alu_res),
    .trace     (trace)
  );

  cpu8_alu cpu8_alu_inst (
    .instr  (alu_instr),
    .a_val  (alu_a),
    .b_val  (alu_b),
    .imm    (alu_imm),
    .result (alu_res)
  );

  cpu8_mem cpu8_mem_inst (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .run      (run),
    .core_req (mem_req),
    .core_rsp (mem_rsp),
    .host_req (host_req),
    .host_rsp (host_rsp)
  );

endmodule

//--- cpu8_core.sv
// fetch, decode and execute sequencer of the 8-bit cpu
// owns the register file and drives one valid/ready request to the memory
// every finished instruction is reported once on the trace port
`include "cpu8_cfg.svh"

module cpu8_core (
  input  logic               in_clk,
  input  logic               in_rst,
  input  logic               run,        // checked at instruction boundaries
  output cpu8_pkg::mem_req_t mem_req,
  input  cpu8_pkg::mem_rsp_t mem_rsp,
  output cpu8_pkg::instr_u   alu_instr,
  output cpu8_pkg::word_t    alu_a,
  output cpu8_pkg::word_t    alu_b,
  output cpu8_pkg::word_t    alu_imm,
  input  cpu8_pkg::alu_out_t alu_res,
  output cpu8_pkg::trace_t   trace
);

  typedef enum logic [2:0] {
    FETCH,       // request word at pc, wait for it
    DECODE,      // pick the immediate or the register path
    LOAD_IMM,    // second word at pc
    EXEC,        // retire or start a data access
    MEM_ACCESS   // LDM / STM in flight
  } state_e;

  state_e             state;
  cpu8_pkg::word_t    regs [`CPU8_NUM_REGS];  // reg 0 doubles as pc
  cpu8_pkg::instr_u   instr_q;
  cpu8_pkg::word_t    imm_q;
  cpu8_pkg::mem_req_t req_q;

  logic              is_imm_form;
  logic              is_ldm;
  logic              is_stm;
  logic              retire;
  logic              wr_en;
  cpu8_pkg::reg_idx_t wr_idx;
  cpu8_pkg::word_t    wr_val;

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------
  assign is_imm_form = !instr_q.r1.fmt && instr_q.r1.imm;
  assign is_ldm      = is_imm_form && (instr_q.r1.op == cpu8_pkg::OP1_LDM);
  assign is_stm      = is_imm_form && (instr_q.r1.op == cpu8_pkg::OP1_STM);

  assign alu_instr = instr_q;
  assign alu_a     = instr_q.r2.fmt ? regs[instr_q.r2.a] : regs[instr_q.r1.a];
  assign alu_b     = regs[instr_q.r2.b];
  assign alu_imm   = imm_q;

  assign mem_req = req_q;

  // ------------------------------------------------------------
  // retire and write-back select
  // ------------------------------------------------------------
  always_comb begin
    retire = 1'b0;
    wr_en  = 1'b0;
    wr_idx = alu_res.dest;
    wr_val = alu_res.value;
    case (state)
      EXEC: begin
        if (!(is_ldm || is_stm)) begin
          retire = 1'b1;
          wr_en  = alu_res.we;  // low for undefined opcodes
        end
      end
      MEM_ACCESS: begin
        if (mem_rsp.ready) begin
          retire = 1'b1;
          wr_en  = is_ldm;
          wr_idx = instr_q.r1.a;
          wr_val = is_ldm ? mem_rsp.rdata : req_q.wdata;  // STM reports the stored word
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    trace.valid = retire;
    trace.instr = instr_q;
    trace.wrote = wr_en;  // a reg 0 write shows up here as a jump
    trace.dest  = wr_idx;
    trace.value = wr_val;
  end

  // ------------------------------------------------------------
  // sequencer
  // ------------------------------------------------------------
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      state       <= FETCH;
      req_q.valid <= 1'b0;
      for (int i = 0; i < `CPU8_NUM_REGS; i++) begin
        regs[i] <= '0;  // pc starts at 0
      end
    end else begin
      case (state)
        FETCH: begin
          if (!req_q.valid) begin
            if (run) begin  // idle here while stopped
              req_q.valid          <= 1'b1;
              req_q.write          <= 1'b0;
              req_q.addr           <= regs[cpu8_pkg::PC_IDX];
              regs[cpu8_pkg::PC_IDX] <= regs[cpu8_pkg::PC_IDX] + 1'b1;
            end
          end else if (mem_rsp.ready) begin
            req_q.valid <= 1'b0;
            instr_q     <= mem_rsp.rdata;
            state       <= DECODE;
          end
        end
        DECODE: begin
          state <= is_imm_form ? LOAD_IMM : EXEC;
        end
        LOAD_IMM: begin
          if (!req_q.valid) begin
            req_q.valid          <= 1'b1;
            req_q.write          <= 1'b0;
            req_q.addr           <= regs[cpu8_pkg::PC_IDX];
            regs[cpu8_pkg::PC_IDX] <= regs[cpu8_pkg::PC_IDX] + 1'b1;
          end else if (mem_rsp.ready) begin
            req_q.valid <= 1'b0;
            imm_q       <= mem_rsp.rdata;
            state       <= EXEC;
          end
        end
        EXEC: begin
          if (is_ldm || is_stm) begin
            req_q.valid <= 1'b1;
            req_q.write <= is_stm;
            req_q.addr  <= imm_q;
            req_q.wdata <= regs[instr_q.r1.a];
            state       <= MEM_ACCESS;
          end else begin
            state <= FETCH;
          end
        end
        MEM_ACCESS: begin
          if (mem_rsp.ready) begin
            req_q.valid <= 1'b0;
            state       <= FETCH;
          end
        end
        default: state <= FETCH;
      endcase
      // register write on retire, overrides the pc bump on a jump
      if (wr_en) begin
        regs[wr_idx] <= wr_val;
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // memory sees a frozen request until it answers
  a_req_stable: assert property (@(posedge in_clk) disable iff (in_rst)
    mem_req.valid && !mem_req.valid == 1'b0 && !mem_rsp.ready |=> $stable(mem_req))
    else $error("core request changed before ready");

  // each retire hands the bus back idle and returns to fetch
  a_retire_to_fetch: assert property (@(posedge in_clk) disable iff (in_rst)
    trace.valid |=> state == FETCH && !mem_req.valid)
    else $error("retire not followed by an idle fetch");

endmodule

//--- cpu8_mem.sv
// program/data memory of the 8-bit cpu with fixed wait states for the core
// host port loads and reads back words while run is low, one-cycle valid pulses
`include "cpu8_cfg.svh"

module cpu8_mem (
  input  logic                in_clk,
  input  logic                in_rst,
  input  logic                run,
  input  cpu8_pkg::mem_req_t  core_req,
  output cpu8_pkg::mem_rsp_t  core_rsp,
  input  cpu8_pkg::host_req_t host_req,
  output cpu8_pkg::host_rsp_t host_rsp
);

  localparam int unsigned WAIT_BITS = $clog2(`CPU8_MEM_WAIT + 1);

  cpu8_pkg::word_t mem [`CPU8_MEM_WORDS];

  logic                 busy;         // core request accepted
  logic [WAIT_BITS-1:0] wait_cnt;     // cycles left until ready
  logic                 core_accept;
  logic                 core_done;
  logic                 host_accept;
  cpu8_pkg::word_t      core_rd_q;
  logic                 host_ready_q;
  cpu8_pkg::word_t      host_rd_q;

  assign core_accept = core_req.valid && !busy;
  assign core_done   = busy && (wait_cnt == '0);
  assign host_accept = host_req.valid && !run && !busy;  // no answer while running

  assign core_rsp.ready = core_done;
  assign core_rsp.rdata = core_rd_q;
  assign host_rsp.ready = host_ready_q;
  assign host_rsp.rdata = host_rd_q;

  // ------------------------------------------------------------
  // wait-state counter
  // ------------------------------------------------------------
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      busy         <= 1'b0;
      wait_cnt     <= '0;
      host_ready_q <= 1'b0;
    end else begin
      host_ready_q <= host_accept;  // one cycle after valid
      if (core_accept) begin
        busy     <= 1'b1;
        wait_cnt <= WAIT_BITS'(`CPU8_MEM_WAIT - 1);
      end else if (core_done) begin
        busy <= 1'b0;
      end else if (busy) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // array
  // ------------------------------------------------------------
  always_ff @(posedge in_clk) begin
    if (core_req.valid) begin
      core_rd_q <= mem[core_req.addr];  // settled by the ready cycle
    end
    if (core_done && core_req.write) begin
      mem[core_req.addr] <= core_req.wdata;
    end else if (host_accept && host_req.write) begin
      mem[host_req.addr] <= host_req.wdata;
    end
    if (host_accept) begin
      host_rd_q <= mem[host_req.addr];
    end
  end

  // core must be parked at a boundary before the host takes over
  a_no_core_when_stopped: assert property (@(posedge in_clk) disable iff (in_rst)
    core_accept |-> run)
    else $error("core request accepted while run is low");

endmodule

//--- cpu8_alu.sv
// combinational result unit of the 8-bit cpu
// decodes the instruction word and returns value, write enable and destination
module cpu8_alu (
  input  cpu8_pkg::instr_u   instr,
  input  cpu8_pkg::word_t    a_val,   // reg[aa]
  input  cpu8_pkg::word_t    b_val,   // reg[bb]
  input  cpu8_pkg::word_t    imm,     // second word of immediate forms
  output cpu8_pkg::alu_out_t result
);

  cpu8_pkg::word_t status;

  // unsigned compare packed into the low six bits
  assign status = {2'b00,
                   a_val == b_val,   // 5
                   a_val != b_val,   // 4
                   a_val <  b_val,   // 3
                   a_val <= b_val,   // 2
                   a_val >  b_val,   // 1
                   a_val >= b_val};  // 0

  always_comb begin
    result.value = a_val;
    result.we    = 1'b0;
    result.dest  = instr.r2.a;
    if (instr.r2.fmt) begin
      // two-register form always writes
      result.we = 1'b1;
      case (instr.r2.op)
        cpu8_pkg::OP2_MOV: begin
          result.value = a_val;
          result.dest  = instr.r2.b;  // transfer goes aa -> bb
        end
        cpu8_pkg::OP2_ADD: result.value = a_val + b_val;  // wraps mod 256
        cpu8_pkg::OP2_SUB: result.value = a_val - b_val;
        cpu8_pkg::OP2_SHL: result.value = a_val << b_val;
        cpu8_pkg::OP2_SHR: result.value = a_val >> b_val;
        cpu8_pkg::OP2_CMP: begin
          result.value = status;
          result.dest  = cpu8_pkg::STATUS_IDX;
        end
        cpu8_pkg::OP2_AND: result.value = a_val & b_val;
        cpu8_pkg::OP2_OR:  result.value = a_val | b_val;
      endcase
    end else begin
      result.dest = instr.r1.a;
      if (instr.r1.imm) begin
        // LDM and STM are finished by the core
        if (instr.r1.op == cpu8_pkg::OP1_LDI) begin
          result.value = imm;
          result.we    = 1'b1;
        end
      end else begin
        case (instr.r1.op)
          cpu8_pkg::OP1_NOT: begin
            result.value = ~a_val;
            result.we    = 1'b1;
          end
          cpu8_pkg::OP1_LNOT: begin
            result.value = {7'd0, a_val == '0};
            result.we    = 1'b1;
          end
          default: result.we = 1'b0;  // undefined, retires as no-op
        endcase
      end
    end
  end

endmodule

//--- cpu8_pkg.sv
// shared types of the 8-bit cpu
// core, alu, memory and testbench refer to these by scoped name
`include "cpu8_cfg.svh"

package cpu8_pkg;

  typedef logic [`CPU8_WORD_BITS-1:0] word_t;            // data or address
  typedef logic [$clog2(`CPU8_NUM_REGS)-1:0] reg_idx_t;  // register number

  localparam reg_idx_t PC_IDX     = 2'd0;  // program counter
  localparam reg_idx_t STATUS_IDX = 2'd3;  // compare result lands here

  // ------------------------------------------------------------
  // opcodes
  // ------------------------------------------------------------
  // two-register form  1_ooo_aa_bb
  typedef enum logic [2:0] {
    OP2_MOV = 3'b000,  // bb = aa
    OP2_ADD = 3'b001,  // aa += bb
    OP2_SUB = 3'b010,  // aa -= bb
    OP2_SHL = 3'b011,  // aa <<= bb
    OP2_SHR = 3'b100,  // aa >>= bb
    OP2_CMP = 3'b101,  // reg 3 = status(aa, bb)
    OP2_AND = 3'b110,
    OP2_OR  = 3'b111
  } op2_e;

  // one-register form  0_i_oooo_aa, i set means an immediate word follows
  typedef enum logic [3:0] {
    OP1_LDI  = 4'b0000,  // aa = imm
    OP1_LDM  = 4'b0001,  // aa = mem[imm]
    OP1_STM  = 4'b0010,  // mem[imm] = aa
    OP1_NOT  = 4'b0100,  // bit-wise
    OP1_LNOT = 4'b0101   // logical, gives 0 or 1
  } op1_e;

  typedef struct packed {
    logic     fmt;  // 1 here
    op2_e     op;
    reg_idx_t a;
    reg_idx_t b;
  } instr2_t;

  typedef struct packed {
    logic     fmt;  // 0 here
    logic     imm;
    op1_e     op;
    reg_idx_t a;
  } instr1_t;

  // same word, layout picked by the top bit
  typedef union packed {
    instr2_t r2;
    instr1_t r1;
  } instr_u;

  // ------------------------------------------------------------
  // ports
  // ------------------------------------------------------------
  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  ready;  // single-cycle pulse
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
  } host_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } host_rsp_t;

  typedef struct packed {
    logic     valid;  // one pulse per retired instruction
    instr_u   instr;
    logic     wrote;  // a register changed
    reg_idx_t dest;
    word_t    value;
  } trace_t;

  typedef struct packed {
    word_t    value;
    logic     we;
    reg_idx_t dest;
  } alu_out_t;

endpackage

//--- cpu8_cfg.svh
// sizes and memory timing for the 8-bit register cpu
// include wherever a width, the register count or the wait states are needed
`ifndef CPU8_CFG_SVH
`define CPU8_CFG_SVH

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------
`define CPU8_WORD_BITS 8    // data and address width, fixed by the opcode format
`define CPU8_NUM_REGS  4    // reg 0 is the pc, reg 3 takes the compare status

// ------------------------------------------------------------
// memory
// ------------------------------------------------------------
`define CPU8_MEM_WORDS 256  // full 8-bit address range
`define CPU8_MEM_WAIT  2    // cycles from request accept to ready, 1 or more

`endif
